// ==== tb.f ====
logic/kernel_pkg.sv
logic/ctrl_slave.sv
logic/ctrl_regs.sv
logic/param_mem.sv
logic/reset_handler.sv
logic/checksum_action.sv
logic/kernel_wrapper.sv
testbench/kernel_wrapper_props.sv
testbench/tb_kernel_wrapper.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the kernel wrapper testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f \
    --top-module tb_kernel_wrapper --Mdir obj_dir -o sim_tb; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/sim_tb 2>&1)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^PASS: all tests$"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi

// ==== testbench/tb_kernel_wrapper.sv ====
// Kernel wrapper testbench
`default_nettype none

module tb_kernel_wrapper;
  import kernel_pkg::*;

  localparam int N_WORDS = 16;
  localparam int ADDR_W = 16;
  localparam int WAIT_LIMIT = 50;
  localparam int POLL_LIMIT = 60;
  localparam logic [ADDR_W-1:0] PARAM_ADDR = ADDR_W'(PARAM_BASE);
  localparam logic [ADDR_W-1:0] CTRL_ADDR = ADDR_W'(ADDR_AP_CTRL);
  localparam logic [ADDR_W-1:0] GIE_ADDR = ADDR_W'(ADDR_GIE);
  localparam logic [ADDR_W-1:0] IER_ADDR = ADDR_W'(ADDR_IER);
  localparam logic [ADDR_W-1:0] ISR_ADDR = ADDR_W'(ADDR_ISR);
  localparam logic [ADDR_W-1:0] RESULT_ADDR = ADDR_W'(ADDR_RESULT);

  logic              ap_clk = 1'b0;
  logic              rst;
  logic              awvalid;
  logic [ADDR_W-1:0] awaddr;
  logic              awready;
  logic              wvalid;
  logic [31:0]       wdata;
  logic [3:0]        wstrb;
  logic              wready;
  logic              bvalid;
  logic [1:0]        bresp;
  logic              bready;
  logic              arvalid;
  logic [ADDR_W-1:0] araddr;
  logic              arready;
  logic              rvalid;
  logic [31:0]       rdata;
  logic [1:0]        rresp;
  logic              rready;
  logic              interrupt;

  // Testbench copy of the parameter memory.
  logic [31:0] params [N_WORDS];
  logic [31:0] last_result;

  // Run results waiting for the comparison process.
  string       name_q [$];
  logic [31:0] exp_q [$];
  logic [31:0] act_q [$];
  string       cmp_name;
  logic [31:0] cmp_exp;
  logic [31:0] cmp_act;
  int          queued = 0;
  int          compared = 0;

  kernel_wrapper #(.SLAVE_ADDR_WIDTH(ADDR_W), .PARAM_WORDS(N_WORDS)) dut0 (.*);

  always #20 ap_clk = ~ap_clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("ERR %s: expected %08h, actual %08h", name, expected, actual));
    end
  endtask

  // Expected checksum, count capped at the last parameter word.
  function automatic logic [31:0] ref_checksum();
    logic [31:0] sum;
    int          n;
    sum = '0;
    n = (params[0] > 32'(N_WORDS - 1)) ? N_WORDS - 1 : int'(params[0]);
    for (int i = 1; i <= n; i++) begin
      sum = sum + params[i];
    end
    return sum;
  endfunction

  task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
    int cnt;
    cnt = 0;
    @(posedge ap_clk);
    awvalid <= 1'b1;
    awaddr <= addr;
    wvalid <= 1'b1;
    wdata <= data;
    @(negedge ap_clk);
    while (!awready) begin
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        fail_run($sformatf("Write to %04h was never accepted", addr));
      end
      @(negedge ap_clk);
    end
    @(posedge ap_clk);
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    cnt = 0;
    @(negedge ap_clk);
    while (!bvalid) begin
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        fail_run($sformatf("Write to %04h got no response", addr));
      end
      @(negedge ap_clk);
    end
    check("write response", 32'h0, 32'(bresp));
    // The response waits a cycle before the host takes it.
    @(posedge ap_clk);
    bready <= 1'b1;
    @(posedge ap_clk);
    bready <= 1'b0;
  endtask

  task automatic host_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
    int cnt;
    cnt = 0;
    @(posedge ap_clk);
    arvalid <= 1'b1;
    araddr <= addr;
    @(negedge ap_clk);
    while (!arready) begin
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        fail_run($sformatf("Read from %04h was never accepted", addr));
      end
      @(negedge ap_clk);
    end
    @(posedge ap_clk);
    arvalid <= 1'b0;
    cnt = 0;
    @(negedge ap_clk);
    while (!rvalid) begin
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        fail_run($sformatf("Read from %04h returned no data", addr));
      end
      @(negedge ap_clk);
    end
    data = rdata;
    check("read response", 32'h0, 32'(rresp));
    // Read data waits a cycle before the host takes it.
    @(posedge ap_clk);
    rready <= 1'b1;
    @(posedge ap_clk);
    rready <= 1'b0;
  endtask

  task automatic wait_interrupt(input logic level, input string what);
    int cnt;
    cnt = 0;
    @(negedge ap_clk);
    while (interrupt !== level) begin
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        fail_run($sformatf("Interrupt did not reach %0b %s", level, what));
      end
      @(negedge ap_clk);
    end
  endtask

  task automatic load_params(input logic [31:0] count);
    params[0] = count;
    for (int i = 1; i < N_WORDS; i++) begin
      params[i] = $urandom;
    end
    for (int i = 0; i < N_WORDS; i++) begin
      host_write(PARAM_ADDR + ADDR_W'(4 * i), params[i]);
    end
  endtask

  // Start a run, poll for done and queue the result for comparison.
  task automatic run_kernel(input string name, input logic clear_isr);
    ap_ctrl_t    ctrl;
    logic [31:0] rd;
    int          polls;
    polls = 0;
    host_write(CTRL_ADDR, 32'h1);
    host_read(CTRL_ADDR, rd);
    ctrl = ap_ctrl_t'(rd);
    while (!ctrl.done) begin
      polls++;
      if (polls > POLL_LIMIT) begin
        fail_run($sformatf("%s never reported done", name));
      end
      host_read(CTRL_ADDR, rd);
      ctrl = ap_ctrl_t'(rd);
    end
    check({name, " idle"}, 32'h1, 32'(ctrl.idle));
    host_read(CTRL_ADDR, rd);
    ctrl = ap_ctrl_t'(rd);
    check({name, " done cleared"}, 32'h0, 32'(ctrl.done));
    host_read(RESULT_ADDR, rd);
    name_q.push_back(name);
    exp_q.push_back(ref_checksum());
    act_q.push_back(rd);
    queued++;
    last_result = rd;
    if (clear_isr) begin
      host_write(ISR_ADDR, 32'h1);
    end
  endtask

  // Compares every queued run result against the reference.
  always @(posedge ap_clk) begin
    if (act_q.size() > 0) begin
      cmp_name = name_q.pop_front();
      cmp_exp = exp_q.pop_front();
      cmp_act = act_q.pop_front();
      check(cmp_name, cmp_exp, cmp_act);
      compared++;
    end
  end

  initial begin
    ap_ctrl_t    ctrl;
    logic [31:0] rd;
    logic [31:0] count;
    int          cnt;
    void'($urandom(32'hc7728f0a));
    rst <= 1'b1;
    awvalid <= 1'b0;
    awaddr <= '0;
    wvalid <= 1'b0;
    wdata <= '0;
    wstrb <= 4'hf;
    bready <= 1'b0;
    arvalid <= 1'b0;
    araddr <= '0;
    rready <= 1'b0;
    repeat (5) @(posedge ap_clk);
    rst <= 1'b0;

    // State right after reset.
    @(negedge ap_clk);
    check("reset ready and valid", 32'h0,
          32'({awready, wready, arready, bvalid, rvalid}));
    host_read(CTRL_ADDR, rd);
    ctrl = ap_ctrl_t'(rd);
    check("reset start", 32'h0, 32'(ctrl.start));
    check("reset done", 32'h0, 32'(ctrl.done));
    check("reset idle", 32'h1, 32'(ctrl.idle));
    @(negedge ap_clk);
    check("reset interrupt", 32'h0, 32'(interrupt));

    for (int i = 0; i < N_WORDS; i++) begin
      params[i] = $urandom;
      host_write(PARAM_ADDR + ADDR_W'(4 * i), params[i]);
    end
    for (int i = 0; i < N_WORDS; i++) begin
      host_read(PARAM_ADDR + ADDR_W'(4 * i), rd);
      check($sformatf("param %0d readback", i), params[i], rd);
    end

    // Edge counts first, then random ones.
    for (int r = 0; r < 10; r++) begin
      case (r)
        0: count = 32'h0;
        1: count = 32'h1;
        2: count = 32'(N_WORDS - 1);
        3: count = 32'(N_WORDS + 3);
        4: count = 32'hffff_fff0;
        default: count = $urandom % 24;
      endcase
      load_params(count);
      run_kernel($sformatf("run %0d count %0h", r, count), 1'b1);
    end

    host_write(GIE_ADDR, 32'h1);
    host_write(IER_ADDR, 32'h1);
    @(negedge ap_clk);
    check("interrupt before run", 32'h0, 32'(interrupt));
    load_params($urandom % N_WORDS);
    run_kernel("irq run", 1'b0);
    wait_interrupt(1'b1, "after an enabled run");
    host_read(ISR_ADDR, rd);
    check("isr after irq run", 32'h1, rd);
    host_write(ISR_ADDR, 32'h1);
    wait_interrupt(1'b0, "after clearing the status");
    host_read(ISR_ADDR, rd);
    check("isr cleared", 32'h0, rd);

    host_write(GIE_ADDR, 32'h0);
    load_params($urandom % N_WORDS);
    run_kernel("no irq run", 1'b0);
    repeat (4) begin
      @(negedge ap_clk);
      check("interrupt with gie clear", 32'h0, 32'(interrupt));
    end
    host_read(ISR_ADDR, rd);
    check("isr without gie", 32'h1, rd);
    host_write(ISR_ADDR, 32'h1);

    // Unmapped offsets, including aliases of the control registers.
    host_read(16'h0080, rd);
    check("unmapped read 0080", 32'h0, rd);
    host_read(16'h1040, rd);
    check("unmapped read 1040", 32'h0, rd);
    host_read(16'hfffc, rd);
    check("unmapped read fffc", 32'h0, rd);
    host_write(16'h0080, $urandom);
    host_write(16'h1040, $urandom);
    host_write(16'h1000, 32'hffff_ffff);
    host_write(16'h1004, 32'hffff_ffff);
    host_write(16'h100c, 32'hffff_ffff);
    for (int i = 0; i < N_WORDS; i++) begin
      host_read(PARAM_ADDR + ADDR_W'(4 * i), rd);
      check($sformatf("param %0d after unmapped writes", i), params[i], rd);
    end
    host_read(CTRL_ADDR, rd);
    ctrl = ap_ctrl_t'(rd);
    check("start after unmapped writes", 32'h0, 32'(ctrl.start));
    check("done after unmapped writes", 32'h0, 32'(ctrl.done));
    check("idle after unmapped writes", 32'h1, 32'(ctrl.idle));
    host_read(GIE_ADDR, rd);
    check("gie after unmapped writes", 32'h0, rd);
    host_read(IER_ADDR, rd);
    check("ier after unmapped writes", 32'h1, rd);
    host_read(ISR_ADDR, rd);
    check("isr after unmapped writes", 32'h0, rd);
    host_read(RESULT_ADDR, rd);
    check("result after unmapped writes", last_result, rd);

    cnt = 0;
    while (compared != queued) begin
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        fail_run("Run results were left waiting for comparison");
      end
      @(negedge ap_clk);
    end
    if (queued == 0 || compared != queued) begin
      fail_run("The comparison process did not check every run result");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/kernel_wrapper_props.sv ====
// Host bus and interrupt assertions
`default_nettype none

module kernel_wrapper_props (
  input logic                              ap_clk,
  input logic                              rst,
  input logic                              awvalid,
  input logic                              wvalid,
  input logic                              awready,
  input logic                              wready,
  input logic                              bvalid,
  input logic                              bready,
  input logic                              rvalid,
  input logic                              rready,
  input logic [kernel_pkg::DATA_WIDTH-1:0] rdata,
  input logic                              interrupt
);

  // A write response stays up until the host takes it.
  a_bvalid_hold: assert property (@(posedge ap_clk) disable iff (rst)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  // Read data is held until rready.
  a_rvalid_hold: assert property (@(posedge ap_clk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("rvalid dropped or rdata changed before rready");

  // Both ready lines pulse together, only for a full write while idle.
  a_ready_pair: assert property (@(posedge ap_clk) disable iff (rst)
    awready || wready |-> awready && wready && awvalid && wvalid && !bvalid && !rvalid)
    else $error("awready and wready differ or a write was taken while busy");

  a_irq_reset: assert property (@(posedge ap_clk) rst |=> !interrupt)
    else $error("interrupt high during reset");

endmodule

bind kernel_wrapper kernel_wrapper_props props0 (
  .ap_clk(ap_clk),
  .rst(rst),
  .awvalid(awvalid),
  .wvalid(wvalid),
  .awready(awready),
  .wready(wready),
  .bvalid(bvalid),
  .bready(bready),
  .rvalid(rvalid),
  .rready(rready),
  .rdata(rdata),
  .interrupt(interrupt)
);

`default_nettype wire

// ==== logic/kernel_wrapper.sv ====
// Kernel wrapper top level
`default_nettype none

module kernel_wrapper #(
  parameter int SLAVE_ADDR_WIDTH = kernel_pkg::SLAVE_ADDR_WIDTH,
  parameter int PARAM_WORDS = kernel_pkg::PARAM_WORDS
) (
  input  logic                                ap_clk,
  input  logic                                rst,
  input  logic                                awvalid,
  input  logic [SLAVE_ADDR_WIDTH-1:0]         awaddr,
  output logic                                awready,
  input  logic                                wvalid,
  input  logic [kernel_pkg::DATA_WIDTH-1:0]   wdata,
  input  logic [kernel_pkg::DATA_WIDTH/8-1:0] wstrb,
  output logic                                wready,
  output logic                                bvalid,
  output logic [1:0]                          bresp,
  input  logic                                bready,
  input  logic                                arvalid,
  input  logic [SLAVE_ADDR_WIDTH-1:0]         araddr,
  output logic                                arready,
  output logic                                rvalid,
  output logic [kernel_pkg::DATA_WIDTH-1:0]   rdata,
  output logic [1:0]                          rresp,
  input  logic                                rready,
  output logic                                interrupt
);
  import kernel_pkg::*;

  reg_req_t              reg_req;
  reg_rsp_t              ctrl_rsp;
  reg_rsp_t              param_rsp;
  param_rd_t             rd_req;
  param_rsp_t            rd_rsp;
  logic                  start_req;
  logic                  accepted;
  logic                  go;
  logic                  done;
  logic                  action_done;
  logic                  kernel_rst;
  logic [DATA_WIDTH-1:0] result;

  ctrl_slave #(
    .SLAVE_ADDR_WIDTH(SLAVE_ADDR_WIDTH),
    .PARAM_WORDS(PARAM_WORDS)
  ) ctrl_slave_u (
    .ap_clk, .rst, .awvalid, .awaddr, .awready, .wvalid, .wdata, .wstrb, .wready,
    .bvalid, .bresp, .bready, .arvalid, .araddr, .arready, .rvalid, .rdata, .rresp,
    .rready, .reg_req, .ctrl_rsp, .param_rsp
  );

  ctrl_regs ctrl_regs_u (
    .ap_clk, .rst, .reg_req, .accepted, .done, .result, .ctrl_rsp, .start_req,
    .interrupt
  );

  param_mem #(.PARAM_WORDS(PARAM_WORDS)) param_mem_u (
    .ap_clk, .rst, .reg_req, .rd_req, .param_rsp, .rd_rsp
  );

  reset_handler reset_handler_u (
    .ap_clk, .rst, .start_req, .action_done, .go, .accepted, .done, .kernel_rst
  );

  checksum_action #(.PARAM_WORDS(PARAM_WORDS)) checksum_action_u (
    .ap_clk, .kernel_rst, .go, .rd_rsp, .rd_req, .done(action_done), .result
  );

endmodule

`default_nettype wire

// ==== logic/checksum_action.sv ====
// Checksum action core
`default_nettype none

module checksum_action #(
  parameter int PARAM_WORDS = kernel_pkg::PARAM_WORDS
) (
  input  logic                              ap_clk,
  input  logic                              kernel_rst,
  input  logic                              go,
  input  kernel_pkg::param_rsp_t            rd_rsp,
  output kernel_pkg::param_rd_t             rd_req,
  output logic                              done,
  output logic [kernel_pkg::DATA_WIDTH-1:0] result
);
  import kernel_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_COUNT,
    S_SUM
  } state_e;

  state_e                 state;
  logic [INDEX_WIDTH-1:0] cap;
  logic [INDEX_WIDTH-1:0] last_q;
  logic [INDEX_WIDTH-1:0] left_q;
  logic [DATA_WIDTH-1:0]  acc_q;

  // Word 0 is the count, limited to the words that exist.
  assign cap = (rd_rsp.data > DATA_WIDTH'(PARAM_WORDS - 1)) ?
               INDEX_WIDTH'(PARAM_WORDS - 1) : rd_rsp.data[INDEX_WIDTH-1:0];

  always_ff @(posedge ap_clk) begin
    if (kernel_rst) begin
      state <= S_IDLE;
      rd_req <= '0;
      done <= 1'b0;
    end else begin
      rd_req.valid <= 1'b0;
      done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (go) begin
            rd_req.valid <= 1'b1;
            rd_req.index <= '0;
            state <= S_COUNT;
          end
        end
        S_COUNT: begin
          if (rd_rsp.valid) begin
            acc_q <= '0;
            last_q <= cap;
            left_q <= cap;
            if (cap == '0) begin
              done <= 1'b1;
              result <= '0;
              state <= S_IDLE;
            end else begin
              rd_req.valid <= 1'b1;
              rd_req.index <= INDEX_WIDTH'(1);
              state <= S_SUM;
            end
          end
        end
        S_SUM: begin
          // Keep one request per cycle until the last word is asked for.
          if (rd_req.valid && rd_req.index != last_q) begin
            rd_req.valid <= 1'b1;
            rd_req.index <= rd_req.index + 1'b1;
          end
          if (rd_rsp.valid) begin
            acc_q <= acc_q + rd_rsp.data;
            left_q <= left_q - 1'b1;
            if (left_q == INDEX_WIDTH'(1)) begin
              done <= 1'b1;
              result <= acc_q + rd_rsp.data;
              state <= S_IDLE;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/reset_handler.sv ====
// Action run and reset sequencing
`default_nettype none

module reset_handler (
  input  logic ap_clk,
  input  logic rst,
  input  logic start_req,
  input  logic action_done,
  output logic go,
  output logic accepted,
  output logic done,
  output logic kernel_rst
);
  import kernel_pkg::*;

  localparam int CNT_WIDTH = $clog2(KERNEL_RESET_CYCLES + 1);

  logic                 busy_q;
  logic                 go_q;
  logic                 launch;
  logic [CNT_WIDTH-1:0] krst_cnt_q;

  // The counter is loaded by rst too, so the action also sees rst.
  assign kernel_rst = (krst_cnt_q != '0);
  assign launch = start_req & ~busy_q & ~kernel_rst;
  assign done = action_done & busy_q;
  assign go = go_q;
  assign accepted = go_q;

  always_ff @(posedge ap_clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      go_q <= 1'b0;
      krst_cnt_q <= CNT_WIDTH'(KERNEL_RESET_CYCLES);
    end else begin
      go_q <= launch;
      if (launch) begin
        busy_q <= 1'b1;
      end else if (done) begin
        busy_q <= 1'b0;
      end
      // Hold the action in reset after every run.
      if (done) begin
        krst_cnt_q <= CNT_WIDTH'(KERNEL_RESET_CYCLES);
      end else if (kernel_rst) begin
        krst_cnt_q <= krst_cnt_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/param_mem.sv ====
// Kernel parameter memory
`default_nettype none

module param_mem #(
  parameter int PARAM_WORDS = kernel_pkg::PARAM_WORDS
) (
  input  logic                   ap_clk,
  input  logic                   rst,
  input  kernel_pkg::reg_req_t   reg_req,
  input  kernel_pkg::param_rd_t  rd_req,
  output kernel_pkg::reg_rsp_t   param_rsp,
  output kernel_pkg::param_rsp_t rd_rsp
);
  import kernel_pkg::*;

  logic [DATA_WIDTH-1:0] mem [PARAM_WORDS];
  logic                  host_wr;
  logic                  host_rd;

  assign host_wr = reg_req.valid & reg_req.write & (reg_req.region == PARAM);
  assign host_rd = reg_req.valid & ~reg_req.write & (reg_req.region == PARAM);

  // Host writes land at the end of the accept cycle.
  always_ff @(posedge ap_clk) begin
    if (host_wr) begin
      mem[reg_req.index] <= reg_req.wdata;
    end
  end

  // Host read port, one cycle latency.
  always_ff @(posedge ap_clk) begin
    param_rsp.rdata <= mem[reg_req.index];
    if (rst) begin
      param_rsp.valid <= 1'b0;
    end else begin
      param_rsp.valid <= host_rd;
    end
  end

  // Action read port.
  // Fully pipelined, a new request may come every cycle.
  always_ff @(posedge ap_clk) begin
    rd_rsp.data <= mem[rd_req.index];
    if (rst) begin
      rd_rsp.valid <= 1'b0;
    end else begin
      rd_rsp.valid <= rd_req.valid;
    end
  end

endmodule

`default_nettype wire

// ==== logic/ctrl_regs.sv ====
// Kernel control registers
`default_nettype none

module ctrl_regs (
  input  logic                              ap_clk,
  input  logic                              rst,
  input  kernel_pkg::reg_req_t              reg_req,
  input  logic                              accepted,
  input  logic                              done,
  input  logic [kernel_pkg::DATA_WIDTH-1:0] result,
  output kernel_pkg::reg_rsp_t              ctrl_rsp,
  output logic                              start_req,
  output logic                              interrupt
);
  import kernel_pkg::*;

  reg_word_u             ap_ctrl_q;
  reg_word_u             wr_word;
  reg_word_u             rd_word;
  logic                  gie_q;
  logic                  ier_q;
  logic                  isr_q;
  logic [DATA_WIDTH-1:0] result_q;
  logic [5:0]            offset;
  logic                  wr_en;
  logic                  rd_en;

  assign offset = {reg_req.index, 2'b00};
  assign wr_en = reg_req.valid & reg_req.write & (reg_req.region == CTRL);
  assign rd_en = reg_req.valid & ~reg_req.write & (reg_req.region == CTRL);
  assign wr_word.raw = reg_req.wdata;
  assign start_req = ap_ctrl_q.ctrl.start;

  always_ff @(posedge ap_clk) begin
    if (rst) begin
      ap_ctrl_q.raw <= '0;
      ap_ctrl_q.ctrl.idle <= 1'b1;
      gie_q <= 1'b0;
      ier_q <= 1'b0;
      isr_q <= 1'b0;
      interrupt <= 1'b0;
    end else begin
      // Done and ready are cleared by reading ap_ctrl.
      if (done) begin
        ap_ctrl_q.ctrl.done <= 1'b1;
        ap_ctrl_q.ctrl.idle <= 1'b1;
      end else if (rd_en && offset == ADDR_AP_CTRL[5:0]) begin
        ap_ctrl_q.ctrl.done <= 1'b0;
      end
      if (accepted) begin
        ap_ctrl_q.ctrl.ready <= 1'b1;
      end else if (rd_en && offset == ADDR_AP_CTRL[5:0]) begin
        ap_ctrl_q.ctrl.ready <= 1'b0;
      end
      // A new start wins over a finishing run.
      if (wr_en && offset == ADDR_AP_CTRL[5:0] && wr_word.ctrl.start) begin
        ap_ctrl_q.ctrl.start <= 1'b1;
        ap_ctrl_q.ctrl.idle <= 1'b0;
      end else if (accepted) begin
        ap_ctrl_q.ctrl.start <= 1'b0;
      end
      if (wr_en && offset == ADDR_GIE[5:0]) begin
        gie_q <= wr_word.raw[0];
      end
      if (wr_en && offset == ADDR_IER[5:0]) begin
        ier_q <= wr_word.raw[0];
      end
      // ISR bit 0 toggles on a write of one.
      if (done) begin
        isr_q <= 1'b1;
      end else if (wr_en && offset == ADDR_ISR[5:0] && wr_word.raw[0]) begin
        isr_q <= ~isr_q;
      end
      interrupt <= gie_q & ier_q & isr_q;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (done) begin
      result_q <= result;
    end
  end

  always_comb begin
    rd_word.raw = '0;
    case (offset)
      ADDR_AP_CTRL[5:0]: rd_word.ctrl = ap_ctrl_q.ctrl;
      ADDR_GIE[5:0]: rd_word.raw[0] = gie_q;
      ADDR_IER[5:0]: rd_word.raw[0] = ier_q;
      ADDR_ISR[5:0]: rd_word.raw[0] = isr_q;
      ADDR_RESULT[5:0]: rd_word.raw = result_q;
      default: rd_word.raw = '0;
    endcase
  end

  // Read answer one cycle after the request.
  always_ff @(posedge ap_clk) begin
    ctrl_rsp.rdata <= rd_word.raw;
    if (rst) begin
      ctrl_rsp.valid <= 1'b0;
    end else begin
      ctrl_rsp.valid <= rd_en;
    end
  end

endmodule

`default_nettype wire

// ==== logic/ctrl_slave.sv ====
// AXI-lite control slave
`default_nettype none

module ctrl_slave #(
  parameter int SLAVE_ADDR_WIDTH = kernel_pkg::SLAVE_ADDR_WIDTH,
  parameter int REG_ADDR_WIDTH = kernel_pkg::REG_ADDR_WIDTH,
  parameter int PARAM_WORDS = kernel_pkg::PARAM_WORDS
) (
  input  logic                                ap_clk,
  input  logic                                rst,
  input  logic                                awvalid,
  input  logic [SLAVE_ADDR_WIDTH-1:0]         awaddr,
  output logic                                awready,
  input  logic                                wvalid,
  input  logic [kernel_pkg::DATA_WIDTH-1:0]   wdata,
  input  logic [kernel_pkg::DATA_WIDTH/8-1:0] wstrb,
  output logic                                wready,
  output logic                                bvalid,
  output logic [1:0]                          bresp,
  input  logic                                bready,
  input  logic                                arvalid,
  input  logic [SLAVE_ADDR_WIDTH-1:0]         araddr,
  output logic                                arready,
  output logic                                rvalid,
  output logic [kernel_pkg::DATA_WIDTH-1:0]   rdata,
  output logic [1:0]                          rresp,
  input  logic                                rready,
  output kernel_pkg::reg_req_t                reg_req,
  input  kernel_pkg::reg_rsp_t                ctrl_rsp,
  input  kernel_pkg::reg_rsp_t                param_rsp
);
  import kernel_pkg::*;

  logic                  busy;
  logic                  wr_accept;
  logic                  rd_accept;
  logic                  rd_wait_q;
  reg_region_e           rd_region_q;
  logic [DATA_WIDTH-1:0] rd_sel;

  // Maps a byte address onto a region and a word index.
  function automatic reg_req_t decode(input logic [SLAVE_ADDR_WIDTH-1:0] addr,
                                      input logic wr,
                                      input logic [DATA_WIDTH-1:0] data);
    logic [REG_ADDR_WIDTH-1:0] offset;
    logic [REG_ADDR_WIDTH-1:0] param_off;
    reg_req_t                  req;
    offset = addr[REG_ADDR_WIDTH-1:0];
    param_off = offset - REG_ADDR_WIDTH'(PARAM_BASE);
    req.valid = 1'b1;
    req.write = wr;
    req.wdata = data;
    req.region = NONE;
    req.index = '0;
    if (addr[SLAVE_ADDR_WIDTH-1:REG_ADDR_WIDTH] == '0) begin
      if (offset < REG_ADDR_WIDTH'(PARAM_BASE)) begin
        req.region = CTRL;
        req.index = offset[INDEX_WIDTH+1:2];
      end else if (param_off < REG_ADDR_WIDTH'(4 * PARAM_WORDS)) begin
        req.region = PARAM;
        req.index = param_off[INDEX_WIDTH+1:2];
      end
    end
    return req;
  endfunction

  // One access at a time; writes win over reads in the same cycle.
  assign busy = bvalid | rd_wait_q | rvalid;
  assign wr_accept = awvalid & wvalid & ~busy;
  assign rd_accept = arvalid & ~busy & ~(awvalid & wvalid);

  assign awready = wr_accept;
  assign wready = wr_accept;
  assign arready = rd_accept;
  assign bresp = 2'b00;
  assign rresp = 2'b00;

  always_comb begin
    reg_req = '0;
    if (wr_accept) begin
      reg_req = decode(awaddr, 1'b1, wdata);
      // Partial writes are dropped but still answered.
      reg_req.valid = &wstrb;
    end else if (rd_accept) begin
      reg_req = decode(araddr, 1'b0, '0);
    end
  end

  // Unmapped reads return zero.
  always_comb begin
    rd_sel = '0;
    if (rd_region_q == CTRL && ctrl_rsp.valid) begin
      rd_sel = ctrl_rsp.rdata;
    end else if (rd_region_q == PARAM && param_rsp.valid) begin
      rd_sel = param_rsp.rdata;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (rst) begin
      bvalid <= 1'b0;
      rd_wait_q <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (wr_accept) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      rd_wait_q <= rd_accept;
      if (rd_wait_q) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Read data is held until the host takes it.
  always_ff @(posedge ap_clk) begin
    if (rd_accept) begin
      rd_region_q <= reg_req.region;
    end
    if (rd_wait_q) begin
      rdata <= rd_sel;
    end
  end

endmodule

`default_nettype wire

// ==== logic/kernel_pkg.sv ====
// Kernel wrapper shared definitions
`default_nettype none

package kernel_pkg;

  // Host and internal bus widths.
  parameter int SLAVE_ADDR_WIDTH = 16;
  parameter int REG_ADDR_WIDTH = 12;
  parameter int DATA_WIDTH = 32;
  parameter int INDEX_WIDTH = 4;

  // Parameter memory size and placement.
  parameter int PARAM_WORDS = 16;
  parameter int PARAM_BASE = 'h40;

  // Control register byte offsets.
  parameter logic [REG_ADDR_WIDTH-1:0] ADDR_AP_CTRL = 12'h000;
  parameter logic [REG_ADDR_WIDTH-1:0] ADDR_GIE = 12'h004;
  parameter logic [REG_ADDR_WIDTH-1:0] ADDR_IER = 12'h008;
  parameter logic [REG_ADDR_WIDTH-1:0] ADDR_ISR = 12'h00c;
  parameter logic [REG_ADDR_WIDTH-1:0] ADDR_RESULT = 12'h010;

  // Cycles the action is held in reset after each run.
  parameter int KERNEL_RESET_CYCLES = 2;

  typedef enum logic [1:0] {
    CTRL,
    PARAM,
    NONE
  } reg_region_e;

  // One decoded host access, valid for a single cycle.
  typedef struct packed {
    logic                   valid;
    logic                   write;
    reg_region_e            region;
    logic [INDEX_WIDTH-1:0] index;
    logic [DATA_WIDTH-1:0]  wdata;
  } reg_req_t;

  typedef struct packed {
    logic                  valid;
    logic [DATA_WIDTH-1:0] rdata;
  } reg_rsp_t;

  // Layout of the ap_ctrl register, start in bit 0.
  typedef struct packed {
    logic [DATA_WIDTH-5:0] reserved;
    logic                  ready;
    logic                  idle;
    logic                  done;
    logic                  start;
  } ap_ctrl_t;

  typedef union packed {
    ap_ctrl_t              ctrl;
    logic [DATA_WIDTH-1:0] raw;
  } reg_word_u;

  typedef struct packed {
    logic                   valid;
    logic [INDEX_WIDTH-1:0] index;
  } param_rd_t;

  typedef struct packed {
    logic                  valid;
    logic [DATA_WIDTH-1:0] data;
  } param_rsp_t;

endpackage

`default_nettype wire
